// File: build.f
hw/commit_pkg.sv
hw/excp_priority.sv
hw/commit_resolve.sv
hw/pipe_ctrl.sv
hw/commit_ctrl_top.sv
tb/commit_ctrl_assertions.sv
tb/tb_commit_ctrl.sv

// File: hw/commit_ctrl_top.sv
// commit control top level
// stage 1 priority pick, stage 2 resolve, flush/pause controller
`timescale 1ns/1ps
`default_nettype none

module commit_ctrl_top
    import commit_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  bundle_t       bundle_i,
    input  logic          bundle_valid_i,
    output logic          bundle_ready_o,
    input  csr_state_t    csr_i,
    input  logic          commit_ready_i,
    input  redirect_t     branch_i,
    input  logic          ex_excp_flush_i,
    input  stall_req_t    stall_i,
    output rf_wr_t  [1:0] rf_wr_o,
    output csr_wr_t       csr_wr_o,
    output excp_report_t  excp_report_o,
    output logic          commit_valid_o,
    output logic [7:0]    flush_o,
    output logic [7:0]    pause_o,
    output logic [31:0]   new_pc_o
);

    picked_t [1:0] picked;
    logic          picked_valid;
    logic          picked_ready;
    logic          kill;
    redirect_t     commit_redirect;
    logic          idle_pause;

    excp_priority u_excp_priority (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .bundle_i       (bundle_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_ready_o (bundle_ready_o),
        .kill_i         (kill),
        .csr_i          (csr_i),
        .picked_o       (picked),
        .picked_valid_o (picked_valid),
        .picked_ready_i (picked_ready)
    );

    commit_resolve u_commit_resolve (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .picked_i       (picked),
        .picked_valid_i (picked_valid),
        .picked_ready_o (picked_ready),
        .csr_i          (csr_i),
        .commit_ready_i (commit_ready_i),
        .rf_wr_o        (rf_wr_o),
        .csr_wr_o       (csr_wr_o),
        .excp_report_o  (excp_report_o),
        .commit_valid_o (commit_valid_o),
        .redirect_o     (commit_redirect),
        .kill_o         (kill),
        .idle_pause_o   (idle_pause)
    );

    pipe_ctrl u_pipe_ctrl (
        .commit_redirect_i (commit_redirect),
        .idle_pause_i      (idle_pause),
        .branch_i          (branch_i),
        .ex_excp_flush_i   (ex_excp_flush_i),
        .stall_i           (stall_i),
        .flush_o           (flush_o),
        .pause_o           (pause_o),
        .new_pc_o          (new_pc_o)
    );

endmodule

`default_nettype wire

// File: hw/commit_pkg.sv
// shared types for the commit control block
// exception cause codes, commit bundle and result structs
// ecode / esubcode lookup for the exception report
`default_nettype none

package commit_pkg;

    typedef enum logic [6:0] {
        excp_no   = 7'd0,
        excp_int  = 7'd1,
        excp_pil  = 7'd2,
        excp_pis  = 7'd3,
        excp_pif  = 7'd4,
        excp_pme  = 7'd5,
        excp_ppi  = 7'd6,
        excp_adef = 7'd7,
        excp_adem = 7'd8,
        excp_ale  = 7'd9,
        excp_sys  = 7'd10,
        excp_brk  = 7'd11,
        excp_ine  = 7'd12,
        excp_ipe  = 7'd13,
        excp_fpd  = 7'd14,
        excp_fpe  = 7'd15,
        excp_tlbr = 7'd16
    } excp_cause_e;

    // one committing instruction
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        logic [31:0]           mem_addr;
        logic [5:0]            excp_mask;   // bit 5 has highest priority
        excp_cause_e [5:0]     excp_cause;
        logic                  is_privilege;
        logic                  is_ertn;
        logic                  is_idle;
        logic                  is_llw_scw;
        logic                  rf_we;
        logic [4:0]            rf_addr;
        logic [31:0]           rf_data;
        logic                  csr_we;
        logic [13:0]           csr_addr;
        logic [31:0]           csr_data;
    } slot_t;

    typedef slot_t [1:0] bundle_t;  // slot 0 is the older one

    typedef struct packed {
        logic [31:0] eentry;
        logic [31:0] era;
        logic [1:0]  plv;          // crmd.plv
        logic        int_pending;
    } csr_state_t;

    typedef struct packed {
        slot_t       slot;
        excp_cause_e final_cause;
        logic        has_excp;
    } picked_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_wr_t;

    typedef struct packed {
        logic        we;
        logic [13:0] addr;
        logic [31:0] data;
        logic        llw_scw;
    } csr_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] badv;
        excp_cause_e cause;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } excp_report_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic buffer;
        logic decode;
        logic dispatch;
        logic execute;
        logic mem;
    } stall_req_t;

    // returns {ecode, esubcode}
    function automatic logic [14:0] excp_encode(input excp_cause_e cause);
        logic [5:0] ecode;
        logic [8:0] esubcode;
        esubcode = 9'd0;
        case (cause)
            excp_pil:  ecode = 6'h01;
            excp_pis:  ecode = 6'h02;
            excp_pif:  ecode = 6'h03;
            excp_pme:  ecode = 6'h04;
            excp_ppi:  ecode = 6'h07;
            excp_adef: ecode = 6'h08;
            excp_adem: begin
                ecode    = 6'h08;
                esubcode = 9'd1;       // memory side of ade
            end
            excp_ale:  ecode = 6'h09;
            excp_sys:  ecode = 6'h0b;
            excp_brk:  ecode = 6'h0c;
            excp_ine:  ecode = 6'h0d;
            excp_ipe:  ecode = 6'h0e;
            excp_fpd:  ecode = 6'h0f;
            excp_fpe:  ecode = 6'h12;
            excp_tlbr: ecode = 6'h3f;
            default:   ecode = 6'h00;  // int and no exception
        endcase
        return {ecode, esubcode};
    endfunction

endpackage

`default_nettype wire

// File: hw/commit_resolve.sv
// commit stage 2
// excepting slot select, ecode encoding, regfile and csr write filtering
// commit redirect for exception, ertn and csr refetch, idle pause
`timescale 1ns/1ps
`default_nettype none

module commit_resolve
    import commit_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  picked_t [1:0] picked_i,
    input  logic          picked_valid_i,
    output logic          picked_ready_o,
    input  csr_state_t    csr_i,
    input  logic          commit_ready_i,
    output rf_wr_t  [1:0] rf_wr_o,
    output csr_wr_t       csr_wr_o,
    output excp_report_t  excp_report_o,
    output logic          commit_valid_o,
    output redirect_t     redirect_o,
    output logic          kill_o,
    output logic          idle_pause_o
);

    slot_t        s0;
    slot_t        s1;
    picked_t      excp_pick;
    logic         exc0;
    logic         exc1;
    logic         exc_any;
    logic         we0;
    logic         we1;
    logic         csr_we0;
    logic         csr_we1;
    logic         csr_keep;
    logic [14:0]  enc;
    rf_wr_t [1:0] rf_wr_d;
    csr_wr_t      csr_wr_d;
    excp_report_t report_d;
    redirect_t    redirect_d;

    rf_wr_t [1:0] rf_wr_q;
    csr_wr_t      csr_wr_q;
    excp_report_t report_q;
    redirect_t    redirect_q;
    logic         idle_q;
    logic         s2_valid;
    logic         load;

    assign s0      = picked_i[0].slot;
    assign s1      = picked_i[1].slot;
    assign exc0    = picked_i[0].has_excp;
    assign exc1    = picked_i[1].has_excp;
    assign exc_any = exc0 || exc1;

    // older slot takes the exception
    assign excp_pick = exc0 ? picked_i[0] : picked_i[1];
    assign enc       = excp_encode(excp_pick.final_cause);

    assign report_d.valid    = exc_any;
    assign report_d.pc       = excp_pick.slot.pc;
    assign report_d.badv     = excp_pick.slot.mem_addr;
    assign report_d.cause    = excp_pick.final_cause;
    assign report_d.ecode    = enc[14:9];
    assign report_d.esubcode = enc[8:0];

    // slot 1 is younger, so an excepting slot 0 blocks it too
    assign we0 = s0.valid && s0.rf_we && !exc0;
    assign we1 = s1.valid && s1.rf_we && !exc0 && !exc1;

    always_comb begin
        rf_wr_d[0].we   = we0 && !(we1 && s0.rf_addr == s1.rf_addr); // younger wins
        rf_wr_d[0].addr = s0.rf_addr;
        rf_wr_d[0].data = s0.rf_data;
        rf_wr_d[1].we   = we1;
        rf_wr_d[1].addr = s1.rf_addr;
        rf_wr_d[1].data = s1.rf_data;
    end

    assign csr_we0  = s0.valid && s0.csr_we;
    assign csr_we1  = s1.valid && s1.csr_we;
    assign csr_keep = (csr_we0 || csr_we1) && !exc_any;

    assign csr_wr_d.we      = csr_keep;
    assign csr_wr_d.addr    = csr_we0 ? s0.csr_addr : s1.csr_addr;
    assign csr_wr_d.data    = csr_we0 ? s0.csr_data : s1.csr_data;
    assign csr_wr_d.llw_scw = !exc_any && ((s0.valid && s0.is_llw_scw) ||
                                           (s1.valid && s1.is_llw_scw));

    always_comb begin
        redirect_d.valid  = 1'b1;
        if (exc_any) begin
            redirect_d.target = csr_i.eentry;
        end else if (s0.valid && s0.is_ertn) begin
            redirect_d.target = csr_i.era;
        end else if (csr_keep) begin
            redirect_d.target = (csr_we0 ? s0.pc : s1.pc) + 32'd4;   // refetch
        end else begin
            redirect_d.valid  = 1'b0;
            redirect_d.target = csr_i.eentry;
        end
    end

    // a redirect being taken also blocks the younger bundle from entering
    assign picked_ready_o = (!s2_valid || commit_ready_i) && !kill_o;
    assign load           = picked_valid_i && picked_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s2_valid <= 1'b0;
        end else if (load) begin
            s2_valid <= 1'b1;
        end else if (commit_ready_i) begin
            s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rf_wr_q    <= rf_wr_d;
            csr_wr_q   <= csr_wr_d;
            report_q   <= report_d;
            redirect_q <= redirect_d;
            idle_q     <= s0.valid && s0.is_idle;
        end
    end

    always_comb begin
        rf_wr_o             = rf_wr_q;
        rf_wr_o[0].we       = rf_wr_q[0].we && s2_valid;
        rf_wr_o[1].we       = rf_wr_q[1].we && s2_valid;
        csr_wr_o            = csr_wr_q;
        csr_wr_o.we         = csr_wr_q.we && s2_valid;
        csr_wr_o.llw_scw    = csr_wr_q.llw_scw && s2_valid;
        excp_report_o       = report_q;
        excp_report_o.valid = report_q.valid && s2_valid;
    end

    assign commit_valid_o    = s2_valid;
    assign redirect_o.valid  = redirect_q.valid && s2_valid && commit_ready_i;
    assign redirect_o.target = redirect_q.target;
    assign kill_o            = redirect_o.valid;
    assign idle_pause_o      = s2_valid && idle_q && !csr_i.int_pending;  // irq wakes

endmodule

`default_nettype wire

// File: hw/excp_priority.sv
// commit stage 1
// per-slot exception priority pick, interrupt and privilege check
// one bundle register with valid/ready handshake and kill
`timescale 1ns/1ps
`default_nettype none

module excp_priority
    import commit_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  bundle_t       bundle_i,
    input  logic          bundle_valid_i,
    output logic          bundle_ready_o,
    input  logic          kill_i,          // redirect from the older bundle
    input  csr_state_t    csr_i,
    output picked_t [1:0] picked_o,
    output logic          picked_valid_o,
    input  logic          picked_ready_i
);

    picked_t [1:0] pick_d;
    picked_t [1:0] pick_q;
    logic          s1_valid;
    logic          take;

    always_comb begin
        excp_cause_e cause;
        logic        bit3_won;
        for (int i = 0; i < 2; i++) begin
            cause    = excp_no;
            bit3_won = 1'b0;
            // ascending scan, the highest set bit wins
            for (int b = 0; b < 6; b++) begin
                if (bundle_i[i].excp_mask[b]) begin
                    cause    = bundle_i[i].excp_cause[b];
                    bit3_won = (b == 3);
                end
            end
            if (bit3_won && bundle_i[i].is_privilege && csr_i.plv != 2'd0)
                cause = excp_ipe;   // privileged op outside plv0
            if (csr_i.int_pending)
                cause = excp_int;
            if (!bundle_i[i].valid)
                cause = excp_no;
            pick_d[i].slot        = bundle_i[i];
            pick_d[i].final_cause = cause;
            pick_d[i].has_excp    = bundle_i[i].valid &&
                                    (|bundle_i[i].excp_mask || csr_i.int_pending);
        end
    end

    // no intake on the kill cycle
    assign bundle_ready_o = (!s1_valid || picked_ready_i) && !kill_i;
    assign take           = bundle_valid_i && bundle_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else if (kill_i) begin
            s1_valid <= 1'b0;
        end else if (take) begin
            s1_valid <= 1'b1;
        end else if (picked_ready_i) begin
            s1_valid <= 1'b0;           // drained into stage 2
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pick_q <= pick_d;
        end
    end

    assign picked_o       = pick_q;
    assign picked_valid_o = s1_valid;

endmodule

`default_nettype wire

// File: hw/pipe_ctrl.sv
// pipeline flush and pause vectors
// bit 0 is pc, bit 7 is writeback
// merges commit redirect and branch target into new pc
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl
    import commit_pkg::*;
(
    input  redirect_t   commit_redirect_i,
    input  logic        idle_pause_i,
    input  redirect_t   branch_i,
    input  logic        ex_excp_flush_i,
    input  stall_req_t  stall_i,
    output logic [7:0]  flush_o,
    output logic [7:0]  pause_o,
    output logic [31:0] new_pc_o
);

    logic       cr;
    logic       br;
    logic [7:0] pause_back;
    logic [7:0] pause_front;

    assign cr = commit_redirect_i.valid;
    assign br = branch_i.valid;

    // pc, icache, instbuffer, id, dispatch, ex, mem, wb
    assign flush_o[0] = cr || br;
    assign flush_o[1] = cr || br;
    assign flush_o[2] = cr || br;
    assign flush_o[3] = cr || br || ex_excp_flush_i;
    assign flush_o[4] = cr || br || ex_excp_flush_i;
    assign flush_o[5] = cr;
    assign flush_o[6] = cr;
    assign flush_o[7] = 1'b0;              // wb is never flushed

    // deepest requester wins
    always_comb begin
        if (stall_i.mem || idle_pause_i) begin
            pause_back = 8'b0111_1111;
        end else if (stall_i.execute) begin
            pause_back = 8'b0011_1111;
        end else if (stall_i.dispatch) begin
            pause_back = 8'b0001_1111;
        end else if (stall_i.decode) begin
            pause_back = 8'b0000_1111;
        end else begin
            pause_back = 8'b0000_0000;
        end
    end

    // buffer stall leaves a flushed icache running
    always_comb begin
        pause_front    = 8'b0000_0000;
        pause_front[0] = stall_i.buffer;
        pause_front[1] = stall_i.buffer && !flush_o[1];
    end

    assign pause_o = pause_back | pause_front;

    assign new_pc_o = cr ? commit_redirect_i.target : branch_i.target;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the commit control testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_commit_ctrl \
    -f build.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_commit_ctrl
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi
exit 0

// File: tb/commit_ctrl_assertions.sv
// concurrent checks on the commit stage 2 outputs
// hold under back-pressure, no writes after a slot 0 exception, reset state
`timescale 1ns/1ps
`default_nettype none

module commit_ctrl_assertions
    import commit_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  picked_t [1:0] picked_i,
    input  logic          picked_valid_i,
    input  logic          picked_ready_o,
    input  logic          commit_ready_i,
    input  logic          commit_valid_o,
    input  rf_wr_t  [1:0] rf_wr_o,
    input  csr_wr_t       csr_wr_o,
    input  excp_report_t  excp_report_o,
    input  redirect_t     redirect_o
);

    // result must not move while the consumer stalls
    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (commit_valid_o && !commit_ready_i) |=>
            (commit_valid_o && $stable(rf_wr_o) && $stable(csr_wr_o) &&
             $stable(excp_report_o))
    ) else $error("commit outputs changed while commit_ready_i was low");

    no_write_after_slot0_excp: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (picked_valid_i && picked_ready_o && picked_i[0].has_excp) |=>
            !(rf_wr_o[0].we || rf_wr_o[1].we || csr_wr_o.we || csr_wr_o.llw_scw)
    ) else $error("write enable high for a bundle with a slot 0 exception");

    quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n_i |=> (!commit_valid_o && !redirect_o.valid && !excp_report_o.valid)
    ) else $error("commit output valid while in reset");

endmodule

bind commit_resolve commit_ctrl_assertions u_commit_ctrl_assertions (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .picked_i       (picked_i),
    .picked_valid_i (picked_valid_i),
    .picked_ready_o (picked_ready_o),
    .commit_ready_i (commit_ready_i),
    .commit_valid_o (commit_valid_o),
    .rf_wr_o        (rf_wr_o),
    .csr_wr_o       (csr_wr_o),
    .excp_report_o  (excp_report_o),
    .redirect_o     (redirect_o)
);

`default_nettype wire

// File: tb/tb_commit_ctrl.sv
// testbench for the commit control block
// lfsr driven bundles, csr state, stall requests and branches
// reference model with a queue of expected commit results
`timescale 1ns/1ps
`default_nettype none

module tb_commit_ctrl
    import commit_pkg::*;
();

    localparam int NUM_BATCHES    = 6;
    localparam int BATCH_BUNDLES  = 150;
    localparam int BATCH_TIMEOUT  = 4000;   // cycles
    localparam int DRAIN_TIMEOUT  = 200;

    typedef struct packed {
        rf_wr_t [1:0] rf;
        csr_wr_t      csr;
        excp_report_t rep;
        redirect_t    redir;
        logic         idle;
    } expect_t;

    logic          clk = 1'b0;
    logic          rst_n_i;
    bundle_t       bundle_i;
    logic          bundle_valid_i;
    logic          bundle_ready_o;
    csr_state_t    csr_i;
    logic          commit_ready_i;
    redirect_t     branch_i;
    logic          ex_excp_flush_i;
    stall_req_t    stall_i;
    rf_wr_t  [1:0] rf_wr_o;
    csr_wr_t       csr_wr_o;
    excp_report_t  excp_report_o;
    logic          commit_valid_o;
    logic [7:0]    flush_o;
    logic [7:0]    pause_o;
    logic [31:0]   new_pc_o;

    logic [31:0]   lfsr_state;
    logic          checking = 1'b0;
    logic          took_flag = 1'b0;   // bundle accepted at the last edge
    expect_t       exp_q[$];
    int            taken = 0;
    int            commits = 0;

    commit_ctrl_top u_commit_ctrl_top (.*);   // tb signals share the port names

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp == act)
            else stop_with_failure($sformatf("mismatch %s expected %h actual %h",
                                             name, exp, act));
    endtask

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'd0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic slot_t random_slot();
        slot_t       s;
        logic [31:0] c;
        s.valid    = rand_bits(3) != 32'd0;
        s.pc       = rand_bits(30) << 2;
        s.mem_addr = rand_bits(32);
        for (int k = 0; k < 6; k++) begin
            s.excp_mask[k]  = rand_bits(4) == 32'd0;
            c               = (rand_bits(5) % 32'd15) + 32'd2;   // pil to tlbr
            s.excp_cause[k] = excp_cause_e'(c[6:0]);
        end
        s.is_privilege = rand_bits(2) == 32'd0;
        s.is_ertn      = rand_bits(3) == 32'd0;
        s.is_idle      = rand_bits(3) == 32'd0;
        s.is_llw_scw   = rand_bits(3) == 32'd0;
        s.rf_we        = rand_bits(2) != 32'd0;
        s.rf_addr      = 5'(rand_bits(2));          // narrow range for same-address hits
        s.rf_data      = rand_bits(32);
        s.csr_we       = rand_bits(2) == 32'd0;
        s.csr_addr     = 14'(rand_bits(14));
        s.csr_data     = rand_bits(32);
        return s;
    endfunction

    // {ecode, esubcode} per cause
    function automatic logic [14:0] ecode_of(input excp_cause_e c);
        case (c)
            excp_pil:  return {6'h01, 9'd0};
            excp_pis:  return {6'h02, 9'd0};
            excp_pif:  return {6'h03, 9'd0};
            excp_pme:  return {6'h04, 9'd0};
            excp_ppi:  return {6'h07, 9'd0};
            excp_adef: return {6'h08, 9'd0};
            excp_adem: return {6'h08, 9'd1};
            excp_ale:  return {6'h09, 9'd0};
            excp_sys:  return {6'h0b, 9'd0};
            excp_brk:  return {6'h0c, 9'd0};
            excp_ine:  return {6'h0d, 9'd0};
            excp_ipe:  return {6'h0e, 9'd0};
            excp_fpd:  return {6'h0f, 9'd0};
            excp_fpe:  return {6'h12, 9'd0};
            excp_tlbr: return {6'h3f, 9'd0};
            default:   return 15'd0;
        endcase
    endfunction

    function automatic expect_t predict(input bundle_t b, input csr_state_t c);
        expect_t          e;
        excp_cause_e [1:0] cause;
        logic [1:0]       has;
        logic [1:0]       rf_keep;
        logic             csr0;
        logic             csr_any;
        logic [14:0]      code;
        int               top;
        int               sel;
        e = '0;
        for (int i = 0; i < 2; i++) begin
            top = -1;
            for (int k = 5; k >= 0; k--) begin
                if (top < 0 && b[i].excp_mask[k])
                    top = k;
            end
            cause[i] = (top < 0) ? excp_no : b[i].excp_cause[top];
            if (top == 3 && b[i].is_privilege && c.plv != 2'd0)
                cause[i] = excp_ipe;
            if (c.int_pending)
                cause[i] = excp_int;
            has[i] = b[i].valid && (top >= 0 || c.int_pending);
            if (!b[i].valid)
                cause[i] = excp_no;
        end
        sel             = has[0] ? 0 : 1;
        code            = ecode_of(cause[sel]);
        e.rep.valid     = |has;
        e.rep.pc        = b[sel].pc;
        e.rep.badv      = b[sel].mem_addr;
        e.rep.cause     = cause[sel];
        e.rep.ecode     = code[14:9];
        e.rep.esubcode  = code[8:0];
        rf_keep[0] = b[0].valid && b[0].rf_we && !has[0];
        rf_keep[1] = b[1].valid && b[1].rf_we && !has[0] && !has[1];
        if (&rf_keep && b[0].rf_addr == b[1].rf_addr)
            rf_keep[0] = 1'b0;                  // older write is dead
        for (int i = 0; i < 2; i++) begin
            e.rf[i].we   = rf_keep[i];
            e.rf[i].addr = b[i].rf_addr;
            e.rf[i].data = b[i].rf_data;
        end
        csr0          = b[0].valid && b[0].csr_we;
        csr_any       = csr0 || (b[1].valid && b[1].csr_we);
        e.csr.we      = csr_any && !(|has);
        e.csr.addr    = csr0 ? b[0].csr_addr : b[1].csr_addr;
        e.csr.data    = csr0 ? b[0].csr_data : b[1].csr_data;
        e.csr.llw_scw = !(|has) && ((b[0].valid && b[0].is_llw_scw) ||
                                    (b[1].valid && b[1].is_llw_scw));
        e.redir.valid = 1'b1;
        if (|has)
            e.redir.target = c.eentry;
        else if (b[0].valid && b[0].is_ertn)
            e.redir.target = c.era;
        else if (e.csr.we)
            e.redir.target = (csr0 ? b[0].pc : b[1].pc) + 32'd4;
        else
            e.redir.valid = 1'b0;
        e.idle = b[0].valid && b[0].is_idle;
        return e;
    endfunction

    task automatic check_commit(input expect_t e);
        check_value("exception report valid", 64'(e.rep.valid), 64'(excp_report_o.valid));
        if (e.rep.valid) begin
            check_value("exception cause", 64'(e.rep.cause), 64'(excp_report_o.cause));
            check_value("exception ecode", 64'(e.rep.ecode), 64'(excp_report_o.ecode));
            check_value("exception esubcode", 64'(e.rep.esubcode),
                        64'(excp_report_o.esubcode));
            check_value("exception pc", 64'(e.rep.pc), 64'(excp_report_o.pc));
            check_value("exception badv", 64'(e.rep.badv), 64'(excp_report_o.badv));
        end
        for (int i = 0; i < 2; i++) begin
            check_value($sformatf("write filter rf%0d we", i), 64'(e.rf[i].we),
                        64'(rf_wr_o[i].we));
            if (e.rf[i].we) begin
                check_value($sformatf("write filter rf%0d addr", i), 64'(e.rf[i].addr),
                            64'(rf_wr_o[i].addr));
                check_value($sformatf("write filter rf%0d data", i), 64'(e.rf[i].data),
                            64'(rf_wr_o[i].data));
            end
        end
        check_value("write filter csr we", 64'(e.csr.we), 64'(csr_wr_o.we));
        check_value("write filter llw_scw", 64'(e.csr.llw_scw), 64'(csr_wr_o.llw_scw));
        if (e.csr.we) begin
            check_value("write filter csr addr", 64'(e.csr.addr), 64'(csr_wr_o.addr));
            check_value("write filter csr data", 64'(e.csr.data), 64'(csr_wr_o.data));
        end
    endtask

    // compares at the falling edge while inputs are settled
    task automatic check_outputs();
        expect_t     e;
        logic        cr;
        logic        idle;
        logic        exp_ready;
        logic [7:0]  exp_flush;
        logic [7:0]  exp_pause;
        logic [31:0] exp_pc;
        int          depth;
        e    = '0;
        cr   = 1'b0;
        idle = 1'b0;
        if (commit_valid_o) begin
            assert (exp_q.size() != 0)
                else stop_with_failure("commit_valid_o is high with no bundle outstanding");
            e = exp_q[0];
            check_commit(e);
            cr   = e.redir.valid && commit_ready_i;
            idle = e.idle && !csr_i.int_pending;
        end else begin
            check_value("idle commit enables",
                        64'({rf_wr_o[0].we, rf_wr_o[1].we, csr_wr_o.we,
                             csr_wr_o.llw_scw, excp_report_o.valid}), 64'd0);
        end
        // stage 1 is full only with two bundles in flight
        exp_ready = (exp_q.size() < 2 || commit_ready_i) && !cr;
        check_value("handshake bundle_ready_o", 64'(exp_ready), 64'(bundle_ready_o));
        exp_flush = 8'd0;
        for (int k = 0; k < 8; k++) begin
            if ((cr && k <= 6) || (branch_i.valid && k <= 4) ||
                (ex_excp_flush_i && (k == 3 || k == 4)))
                exp_flush[k] = 1'b1;
        end
        if (stall_i.mem || idle)
            depth = 7;
        else if (stall_i.execute)
            depth = 6;
        else if (stall_i.dispatch)
            depth = 5;
        else if (stall_i.decode)
            depth = 4;
        else
            depth = 0;
        exp_pause    = 8'((1 << depth) - 1);
        exp_pause[0] = exp_pause[0] | stall_i.buffer;
        exp_pause[1] = exp_pause[1] | (stall_i.buffer && !exp_flush[1]);
        exp_pc       = cr ? e.redir.target : branch_i.target;
        check_value("flush vector", 64'(exp_flush), 64'(flush_o));
        check_value("pause vector", 64'(exp_pause), 64'(pause_o));
        check_value("redirect new_pc", 64'(exp_pc), 64'(new_pc_o));
        if (commit_valid_o && commit_ready_i) begin
            void'(exp_q.pop_front());
            if (e.redir.valid)
                exp_q.delete();      // younger bundle in stage 1 is killed
            commits++;
        end
        took_flag = bundle_valid_i && bundle_ready_o;
        if (took_flag) begin
            exp_q.push_back(predict(bundle_i, csr_i));
            taken++;
        end
    endtask

    always @(negedge clk) begin
        if (checking)
            check_outputs();
    end

    task automatic drive_cycle(input logic feed);
        @(posedge clk);
        #1;
        if (took_flag || !bundle_valid_i) begin   // an offered bundle stays until taken
            bundle_valid_i = feed && rand_bits(2) != 32'd0;
            if (bundle_valid_i) begin
                bundle_i[0] = random_slot();
                bundle_i[1] = random_slot();
            end
        end
        csr_i.plv         = 2'(rand_bits(2));
        csr_i.int_pending = rand_bits(5) == 32'd0;
        commit_ready_i    = rand_bits(2) != 32'd0;
        branch_i.valid    = rand_bits(3) == 32'd0;
        branch_i.target   = rand_bits(32);
        ex_excp_flush_i   = rand_bits(3) == 32'd0;
        stall_i.buffer    = rand_bits(3) == 32'd0;
        stall_i.decode    = rand_bits(3) == 32'd0;
        stall_i.dispatch  = rand_bits(3) == 32'd0;
        stall_i.execute   = rand_bits(3) == 32'd0;
        stall_i.mem       = rand_bits(3) == 32'd0;
    endtask

    task automatic run_batch();
        int cycles;
        int start;
        cycles = 0;
        start  = taken;
        while (taken - start < BATCH_BUNDLES) begin
            drive_cycle(1'b1);
            cycles++;
            if (cycles > BATCH_TIMEOUT)
                stop_with_failure("timeout: bundles were not accepted by the DUT");
        end
    endtask

    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || bundle_valid_i || commit_valid_o) begin
            drive_cycle(1'b0);
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
                stop_with_failure("timeout: the pipeline did not drain");
        end
    endtask

    initial begin
        lfsr_state      = 32'haf3d22fd;
        rst_n_i         = 1'b0;
        bundle_i        = '0;
        bundle_valid_i  = 1'b0;
        csr_i           = '0;
        commit_ready_i  = 1'b0;
        branch_i        = '0;
        ex_excp_flush_i = 1'b0;
        stall_i         = '0;
        repeat (5) @(posedge clk);
        #1;
        check_value("reset bundle_ready_o", 64'd1, 64'(bundle_ready_o));
        check_value("reset commit_valid_o", 64'd0, 64'(commit_valid_o));
        check_value("reset flush vector", 64'd0, 64'(flush_o));
        check_value("reset pause vector", 64'd0, 64'(pause_o));
        rst_n_i  = 1'b1;
        checking = 1'b1;
        for (int batch = 0; batch < NUM_BATCHES; batch++) begin
            // vector bases change only while the pipeline is empty
            csr_i.eentry = rand_bits(26) << 6;
            csr_i.era    = rand_bits(30) << 2;
            run_batch();
            drain_pipeline();
        end
        $display("%0d bundles accepted, %0d committed", taken, commits);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
